//--- sources.f
+incdir+.
oflow_pkg.sv
oflow_div_seq.sv
oflow_bbox_pair_gen.sv
oflow_pair_fifo.sv
oflow_calc_iou.sv
oflow_iou_top.sv
oflow_iou_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the IoU stage testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module oflow_iou_tb

./obj_dir/Voflow_iou_tb | tee sim.log

if grep -q "TESTBENCH PASSED" sim.log; then
	echo "simulation ok"
	exit 0
else
	echo "simulation failed, see sim.log"
	exit 1
fi

//--- oflow_iou_tb_ref.svh
// ------------------------------
// IoU testbench reference model
// expected Q0.22 cost from box corners and
// the queue of results still to arrive
// ------------------------------
`ifndef OFLOW_IOU_TB_REF_SVH
`define OFLOW_IOU_TB_REF_SVH

iou_result_t exp_q[$];                      // pending results, arrival order
bbox_t       hist_model[`OFLOW_HIST_DEPTH]; // mirror of the history table
int          hist_n;                        // boxes in the closed frame
int          pushed;                        // expected results so far

// one side length, zero when the corners cross
function automatic longint side_len(input longint lo, input longint hi);
	return (hi > lo) ? hi - lo : 0;
endfunction

// cost = 1 - inter/union in Q0.22
function automatic logic [`OFLOW_FRAC_W-1:0] iou_cost_ref(input bbox_t a, input bbox_t b);
	longint lo_x;
	longint hi_x;
	longint lo_y;
	longint hi_y;
	longint inter;
	longint uni;
	longint q;
	lo_x  = (a.x_tl > b.x_tl) ? a.x_tl : b.x_tl;
	hi_x  = (a.x_br < b.x_br) ? a.x_br : b.x_br;
	lo_y  = (a.y_tl > b.y_tl) ? a.y_tl : b.y_tl;
	hi_y  = (a.y_br < b.y_br) ? a.y_br : b.y_br;
	inter = side_len(lo_x, hi_x) * side_len(lo_y, hi_y);   // zero if disjoint
	uni   = side_len(a.x_tl, a.x_br) * side_len(a.y_tl, a.y_br)
	      + side_len(b.x_tl, b.x_br) * side_len(b.y_tl, b.y_br) - inter;
	if (uni == 0)
		return '1;                                  // no area at all
	q = (inter << `OFLOW_FRAC_W) / uni;             // floor
	if (q >= (longint'(1) << `OFLOW_FRAC_W))
		return '0;                                  // identical boxes
	return `OFLOW_FRAC_W'(((longint'(1) << `OFLOW_FRAC_W) - 1) - q);
endfunction

// one expected result per stored history box, hist_idx order
task automatic expect_pairs(input bbox_t cur, input logic [`OFLOW_IDX_W-1:0] cur_idx);
	iou_result_t r;
	for (int i = 0; i < hist_n; i++) begin
		r.cur_idx  = cur_idx;
		r.hist_idx = i[`OFLOW_IDX_W-1:0];
		r.cost     = iou_cost_ref(cur, hist_model[i]);
		exp_q.push_back(r);
		pushed++;
	end
endtask

`endif

//--- oflow_iou_tb.sv
// ------------------------------
// testbench for the IoU association stage
// loads history frames, sends current boxes,
// checks every cost against a reference model
// ------------------------------
`timescale 1ns/1ps
`include "oflow_params.svh"

module oflow_iou_tb import oflow_pkg::*; ();

	localparam int N_RAND      = 12;   // random current boxes in test 4
	localparam int TOTAL_PAIRS = 1 + 2 + 4 + N_RAND * `OFLOW_HIST_DEPTH + 3 * 2;
	localparam int MAX_CYCLES  = TOTAL_PAIRS * (`OFLOW_QUOT_W + 8) + 400;

	logic        clk;
	logic        reset_N;
	logic        hist_valid;
	logic        hist_ready;
	bbox_t       hist_box;
	logic        hist_last;
	logic        cur_valid;
	logic        cur_ready;
	bbox_t       cur_box;
	logic        res_valid;
	logic        res_ready;
	iou_result_t res;

	logic [`OFLOW_IDX_W-1:0] cur_cnt;  // running count of accepted current boxes
	iou_result_t exp_res;
	int          errors;
	int          rx_count;
	int          cycles;
	int          tests_pass;
	int          tests_fail;
	int          err0;
	int          rx0;
	int          push0;
	logic        bp_on;                // random res_ready

	oflow_iou_top oflow_iou_top_inst (
		.clk        (clk),
		.reset_N    (reset_N),
		.hist_valid (hist_valid),
		.hist_ready (hist_ready),
		.hist_box   (hist_box),
		.hist_last  (hist_last),
		.cur_valid  (cur_valid),
		.cur_ready  (cur_ready),
		.cur_box    (cur_box),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.res        (res)
	);

	`include "oflow_iou_tb_ref.svh"

	always #10 clk = ~clk;

	// ------------------------------
	// timeout and result sink
	// ------------------------------
	always @(posedge clk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("timeout after %0d cycles, %0d results missing", cycles, exp_q.size());
			$display("TESTBENCH FAILED");
			$finish;
		end
	end

	always @(posedge clk) begin
		#1;
		if (bp_on)
			res_ready = ($urandom_range(0, 1) != 0);
		else
			res_ready = 1'b1;
	end

	// sampled at negedge ahead of the transfer edge
	always @(negedge clk) begin
		if (reset_N && res_valid && res_ready) begin
			rx_count++;
			assert (exp_q.size() != 0) else begin
				$display("result arrived while no result was expected");
				errors++;
			end
			if (exp_q.size() != 0) begin
				exp_res = exp_q.pop_front();
				assert (res.cur_idx == exp_res.cur_idx) else begin
					$display("FAIL res.cur_idx got %h expected %h", res.cur_idx, exp_res.cur_idx);
					errors++;
				end
				assert (res.hist_idx == exp_res.hist_idx) else begin
					$display("FAIL res.hist_idx got %h expected %h", res.hist_idx,
						exp_res.hist_idx);
					errors++;
				end
				assert (res.cost == exp_res.cost) else begin
					$display("FAIL res.cost got %h expected %h", res.cost, exp_res.cost);
					errors++;
				end
			end
		end
	end

	// ------------------------------
	// stimulus helpers entered at posedge + 1
	// ------------------------------
	function automatic bbox_t mk_box(input int x0, input int y0, input int x1, input int y1);
		bbox_t b;
		b.x_tl = `OFLOW_COORD_W'(x0);
		b.y_tl = `OFLOW_COORD_W'(y0);
		b.x_br = `OFLOW_COORD_W'(x1);
		b.y_br = `OFLOW_COORD_W'(y1);
		return b;
	endfunction

	function automatic bbox_t rand_box();
		bbox_t b;
		b.x_tl = `OFLOW_COORD_W'($urandom_range(0, 300));
		b.y_tl = `OFLOW_COORD_W'($urandom_range(0, 300));
		b.x_br = b.x_tl + `OFLOW_COORD_W'($urandom_range(0, 200));  // may be empty
		b.y_br = b.y_tl + `OFLOW_COORD_W'($urandom_range(0, 200));
		return b;
	endfunction

	// one handshake flag against its expected level
	task automatic check_flag(input string name, input logic got, input logic want);
		assert (got === want) else begin
			$display("FAIL %s got %h expected %h", name, got, want);
			errors++;
		end
	endtask

	task automatic send_hist(input bbox_t b, input logic last);
		hist_box   = b;
		hist_last  = last;
		hist_valid = 1'b1;
		@(negedge clk);
		while (!hist_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		hist_valid = 1'b0;
	endtask

	task automatic load_history(input int n);
		for (int i = 0; i < n; i++)
			send_hist(hist_model[i], i == n - 1);
		hist_n = n;
	endtask

	task automatic send_cur(input bbox_t b);
		expect_pairs(b, cur_cnt);
		cur_box   = b;
		cur_valid = 1'b1;
		@(negedge clk);
		while (!cur_ready)
			@(negedge clk);
		@(posedge clk);
		#1;
		cur_valid = 1'b0;
		cur_cnt   = cur_cnt + 1'b1;
	endtask

	task automatic begin_test();
		err0  = errors;
		rx0   = rx_count;
		push0 = pushed;
	endtask

	// drain and report one test
	task automatic end_test(input int num, input string name);
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);
		#1;
		assert (rx_count - rx0 == pushed - push0) else begin
			$display("test %0d got %0d results instead of %0d", num, rx_count - rx0,
				pushed - push0);
			errors++;
		end
		if (errors == err0) begin
			tests_pass++;
			$display("test %0d %s: ok", num, name);
		end else begin
			tests_fail++;
			$display("test %0d %s: %0d errors", num, name, errors - err0);
		end
	endtask

	// ------------------------------
	// test sequence
	// ------------------------------
	initial begin
		clk        = 1'b0;
		reset_N    = 1'b0;
		hist_valid = 1'b0;
		hist_box   = '0;
		hist_last  = 1'b0;
		cur_valid  = 1'b0;
		cur_box    = '0;
		res_ready  = 1'b0;
		bp_on      = 1'b0;
		cur_cnt    = '0;
		hist_n     = 0;
		pushed     = 0;
		errors     = 0;
		rx_count   = 0;
		cycles     = 0;
		tests_pass = 0;
		tests_fail = 0;
		void'($urandom(42));
		repeat (10) @(posedge clk);
		#1;
		reset_N = 1'b1;

		begin_test();                                   // partial overlap
		check_flag("hist_ready", hist_ready, 1'b1);     // state out of reset
		check_flag("cur_ready", cur_ready, 1'b0);       // no closed frame yet
		check_flag("res_valid", res_valid, 1'b0);
		hist_model[0] = mk_box(100, 100, 200, 200);
		load_history(1);
		send_cur(mk_box(150, 150, 250, 250));
		end_test(1, "partial overlap");

		begin_test();
		hist_model[0] = mk_box(10, 10, 60, 40);
		load_history(1);
		send_cur(mk_box(300, 300, 350, 380));           // disjoint
		send_cur(mk_box(10, 10, 60, 40));               // identical
		end_test(2, "disjoint and identical");

		begin_test();
		hist_model[0] = mk_box(0, 0, 100, 100);
		hist_model[1] = mk_box(50, 50, 150, 150);
		hist_model[2] = mk_box(90, 0, 190, 80);
		hist_model[3] = mk_box(500, 500, 600, 600);
		load_history(4);
		send_cur(mk_box(40, 40, 140, 120));
		end_test(3, "four-entry history");

		begin_test();
		bp_on = 1'b1;
		for (int i = 0; i < `OFLOW_HIST_DEPTH; i++)
			hist_model[i] = rand_box();
		load_history(`OFLOW_HIST_DEPTH);
		for (int i = 0; i < N_RAND; i++)
			send_cur(rand_box());
		end_test(4, "random under back-pressure");
		bp_on = 1'b0;

		begin_test();                                   // shorter frame replaces 4
		hist_model[0] = mk_box(20, 20, 80, 80);
		hist_model[1] = mk_box(60, 60, 160, 100);
		load_history(2);
		send_cur(mk_box(30, 30, 90, 90));
		send_cur(mk_box(70, 70, 70, 120));              // zero width
		send_cur(mk_box(100, 50, 100, 50));             // point box
		end_test(5, "history reload");

		repeat (20) @(posedge clk);                     // catch stray results
		$display("tests passed %0d failed %0d, results %0d, errors %0d",
			tests_pass, tests_fail, rx_count, errors);
		if (errors == 0 && tests_fail == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end

endmodule

//--- oflow_iou_top.sv
// ------------------------------
// IoU association stage top
// pair generator, pair FIFO, cost block
// ------------------------------
`timescale 1ns/1ps
`include "oflow_params.svh"

module oflow_iou_top import oflow_pkg::*; (
	input  logic        clk,
	input  logic        reset_N,
	input  logic        hist_valid,
	output logic        hist_ready,
	input  bbox_t       hist_box,
	input  logic        hist_last,
	input  logic        cur_valid,
	output logic        cur_ready,
	input  bbox_t       cur_box,
	output logic        res_valid,
	input  logic        res_ready,
	output iou_result_t res
);

	// producer side of the FIFO
	logic       gen_pair_valid;
	logic       gen_pair_ready;
	bbox_pair_t gen_pair;
	// consumer side
	logic       iou_pair_valid;
	logic       iou_pair_ready;
	bbox_pair_t iou_pair;

	oflow_bbox_pair_gen oflow_bbox_pair_gen_inst (
		.clk        (clk),
		.reset_N    (reset_N),
		.hist_valid (hist_valid),
		.hist_ready (hist_ready),
		.hist_box   (hist_box),
		.hist_last  (hist_last),
		.cur_valid  (cur_valid),
		.cur_ready  (cur_ready),
		.cur_box    (cur_box),
		.pair_valid (gen_pair_valid),
		.pair_ready (gen_pair_ready),
		.pair       (gen_pair)
	);

	oflow_pair_fifo #(
		.item_t (bbox_pair_t),
		.DEPTH  (`OFLOW_FIFO_DEPTH)
	) oflow_pair_fifo_inst (
		.clk       (clk),
		.reset_N   (reset_N),
		.in_valid  (gen_pair_valid),
		.in_ready  (gen_pair_ready),
		.in_data   (gen_pair),
		.out_valid (iou_pair_valid),
		.out_ready (iou_pair_ready),
		.out_data  (iou_pair)
	);

	oflow_calc_iou oflow_calc_iou_inst (
		.clk        (clk),
		.reset_N    (reset_N),
		.pair_valid (iou_pair_valid),
		.pair_ready (iou_pair_ready),
		.pair       (iou_pair),
		.res_valid  (res_valid),
		.res_ready  (res_ready),
		.res        (res)
	);

endmodule

//--- oflow_calc_iou.sv
// ------------------------------
// IoU cost consumer
// intersection and union of one pair, then
// sequential divide and Q0.22 cost 1 - iou
// ------------------------------
`timescale 1ns/1ps
`include "oflow_params.svh"

module oflow_calc_iou import oflow_pkg::*; (
	input  logic        clk,
	input  logic        reset_N,
	input  logic        pair_valid,
	output logic        pair_ready,
	input  bbox_pair_t  pair,
	output logic        res_valid,
	input  logic        res_ready,
	output iou_result_t res
);

	localparam int COORD_W = `OFLOW_COORD_W;
	localparam int AREA_W  = `OFLOW_AREA_W;
	localparam int UNION_W = `OFLOW_UNION_W;
	localparam int FRAC_W  = `OFLOW_FRAC_W;
	localparam int QUOT_W  = `OFLOW_QUOT_W;
	localparam int DVD_W   = AREA_W + FRAC_W;  // intersection << frac

	typedef enum logic [2:0] {S_IDLE, S_COORD, S_AREA, S_DIV, S_RES} state_t;

	state_t             state;
	state_t             next_state;
	bbox_pair_t         pair_q;
	logic [COORD_W-1:0] ix_tl_q;   // intersection corners, unclamped
	logic [COORD_W-1:0] iy_tl_q;
	logic [COORD_W-1:0] ix_br_q;
	logic [COORD_W-1:0] iy_br_q;
	logic [COORD_W-1:0] cw_q;      // current box w/h
	logic [COORD_W-1:0] ch_q;
	logic [COORD_W-1:0] hw_q;      // history box w/h
	logic [COORD_W-1:0] hh_q;
	logic [AREA_W-1:0]  area_cur;
	logic [AREA_W-1:0]  area_hist;
	logic [AREA_W-1:0]  inter_d;
	logic [UNION_W-1:0] union_d;
	logic [AREA_W-1:0]  inter_q;
	logic [UNION_W-1:0] union_q;
	logic               div_start;
	logic               div_done;
	logic [QUOT_W-1:0]  quot;
	logic [FRAC_W-1:0]  cost_d;

	function automatic logic [COORD_W-1:0] max_c(input logic [COORD_W-1:0] a, b);
		return (a > b) ? a : b;
	endfunction

	function automatic logic [COORD_W-1:0] min_c(input logic [COORD_W-1:0] a, b);
		return (a < b) ? a : b;
	endfunction

	// extent between two corners, zero when empty
	function automatic logic [COORD_W-1:0] span(input logic [COORD_W-1:0] lo, hi);
		return (hi > lo) ? hi - lo : '0;
	endfunction

	oflow_div_seq #(
		.DIVIDEND_W (DVD_W),
		.DIVISOR_W  (UNION_W),
		.QUOT_W     (QUOT_W)
	) oflow_div_seq_inst (
		.clk      (clk),
		.reset_N  (reset_N),
		.start    (div_start),
		.dividend ({inter_q, {FRAC_W{1'b0}}}),
		.divisor  (union_q),
		.done     (div_done),
		.quotient (quot)
	);

	// ------------------------------
	// FSM
	// ------------------------------
	assign pair_ready = (state == S_IDLE);
	assign res_valid  = (state == S_RES);

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:  if (pair_valid) next_state = S_COORD;
			S_COORD: next_state = S_AREA;
			S_AREA:  next_state = S_DIV;
			S_DIV:   if (union_q == '0 || div_done) next_state = S_RES;  // empty union skips divide
			S_RES:   if (res_ready) next_state = S_IDLE;
			default: next_state = S_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state     <= S_IDLE;
			div_start <= 1'b0;
		end else begin
			state     <= next_state;
			div_start <= (state == S_AREA) && (union_d != '0);  // one cycle pulse
		end
	end

	// ------------------------------
	// datapath
	// ------------------------------
	always_comb begin
		area_cur  = AREA_W'(cw_q) * AREA_W'(ch_q);
		area_hist = AREA_W'(hw_q) * AREA_W'(hh_q);
		inter_d   = AREA_W'(span(ix_tl_q, ix_br_q)) * AREA_W'(span(iy_tl_q, iy_br_q));
		union_d   = UNION_W'(area_cur) + UNION_W'(area_hist) - UNION_W'(inter_d);
		if (union_q == '0)
			cost_d = '1;                                  // nothing to compare
		else if (quot[QUOT_W-1])
			cost_d = '0;                                  // iou saturates at 1.0
		else
			cost_d = {FRAC_W{1'b1}} - quot[FRAC_W-1:0];
	end

	always_ff @(posedge clk) begin
		if (state == S_IDLE && pair_valid)
			pair_q <= pair;
		if (state == S_COORD) begin
			ix_tl_q <= max_c(pair_q.cur_box.x_tl, pair_q.hist_box.x_tl);
			iy_tl_q <= max_c(pair_q.cur_box.y_tl, pair_q.hist_box.y_tl);
			ix_br_q <= min_c(pair_q.cur_box.x_br, pair_q.hist_box.x_br);
			iy_br_q <= min_c(pair_q.cur_box.y_br, pair_q.hist_box.y_br);
			cw_q    <= span(pair_q.cur_box.x_tl, pair_q.cur_box.x_br);
			ch_q    <= span(pair_q.cur_box.y_tl, pair_q.cur_box.y_br);
			hw_q    <= span(pair_q.hist_box.x_tl, pair_q.hist_box.x_br);
			hh_q    <= span(pair_q.hist_box.y_tl, pair_q.hist_box.y_br);
		end
		if (state == S_AREA) begin
			inter_q <= inter_d;
			union_q <= union_d;
		end
		if (state == S_DIV && next_state == S_RES) begin  // result register
			res.cur_idx  <= pair_q.cur_idx;
			res.hist_idx <= pair_q.hist_idx;
			res.cost     <= cost_d;
		end
	end

	a_res_stable: assert property (@(posedge clk) disable iff (!reset_N)
		res_valid && !res_ready |=> res_valid && $stable(res));

endmodule

//--- oflow_pair_fifo.sv
// ------------------------------
// valid/ready FIFO for pair beats
// circular buffer with occupancy count,
// push and pop together allowed when full
// ------------------------------
`timescale 1ns/1ps
`include "oflow_params.svh"

module oflow_pair_fifo #(
	parameter type item_t = logic [7:0],
	parameter int  DEPTH  = `OFLOW_FIFO_DEPTH
) (
	input  logic  clk,
	input  logic  reset_N,
	input  logic  in_valid,
	output logic  in_ready,
	input  item_t in_data,
	output logic  out_valid,
	input  logic  out_ready,
	output item_t out_data
);

	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	item_t            mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count;   // occupancy
	logic             push;
	logic             pop;

	// wrap for non power of two depths
	function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	// ------------------------------
	// flags
	// ------------------------------
	assign out_valid = (count != '0);
	assign in_ready  = (count != CNT_W'(DEPTH)) || out_ready;  // full, but a slot frees
	assign push      = in_valid && in_ready;
	assign pop       = out_valid && out_ready;
	assign out_data  = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push)
			mem[wr_ptr] <= in_data;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count  <= '0;
		end else begin
			if (push)
				wr_ptr <= ptr_inc(wr_ptr);
			if (pop)
				rd_ptr <= ptr_inc(rd_ptr);
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;    // idle or both
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge clk) disable iff (!reset_N)
		count <= CNT_W'(DEPTH));

endmodule

//--- oflow_bbox_pair_gen.sv
// ------------------------------
// history pairing producer
// stores the history frame boxes and emits one
// tagged pair per history entry for every
// accepted current-frame box
// ------------------------------
`timescale 1ns/1ps
`include "oflow_params.svh"

module oflow_bbox_pair_gen import oflow_pkg::*; (
	input  logic       clk,
	input  logic       reset_N,
	input  logic       hist_valid,
	output logic       hist_ready,
	input  bbox_t      hist_box,
	input  logic       hist_last,
	input  logic       cur_valid,
	output logic       cur_ready,
	input  bbox_t      cur_box,
	output logic       pair_valid,
	input  logic       pair_ready,
	output bbox_pair_t pair
);

	localparam int DEPTH = `OFLOW_HIST_DEPTH;
	localparam int IDX_W = `OFLOW_IDX_W;

	bbox_t            hist_tbl [DEPTH];  // history frame boxes
	logic [IDX_W-1:0] wr_ptr;            // next table slot
	logic [IDX_W:0]   hist_cnt;          // boxes in closed frame
	logic             frame_ok;          // table holds a closed frame
	logic             emitting;
	logic [IDX_W-1:0] emit_idx;          // table walk
	logic [IDX_W-1:0] cur_idx_q;         // running current box index
	bbox_t            cur_box_q;
	logic             hist_fire;
	logic             cur_fire;
	logic             pair_fire;
	logic             last_pair;

	// ------------------------------
	// handshakes
	// ------------------------------
	assign cur_ready  = !emitting && frame_ok;
	// no table write on the edge that starts a walk
	assign hist_ready = !emitting && !(cur_valid && frame_ok);
	assign hist_fire  = hist_valid && hist_ready;
	assign cur_fire   = cur_valid && cur_ready;
	assign pair_fire  = pair_valid && pair_ready;
	assign pair_valid = emitting;
	assign last_pair  = ({1'b0, emit_idx} == hist_cnt - 1'b1);

	always_comb begin
		pair.cur_box  = cur_box_q;
		pair.hist_box = hist_tbl[emit_idx];
		pair.cur_idx  = cur_idx_q;
		pair.hist_idx = emit_idx;
	end

	// history table and latched current box
	always_ff @(posedge clk) begin
		if (hist_fire)
			hist_tbl[wr_ptr] <= hist_box;
		if (cur_fire)
			cur_box_q <= cur_box;
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			wr_ptr    <= '0;
			hist_cnt  <= '0;
			frame_ok  <= 1'b0;
			emitting  <= 1'b0;
			emit_idx  <= '0;
			cur_idx_q <= '0;
		end else begin
			if (hist_fire) begin
				if (hist_last) begin
					wr_ptr   <= '0;                     // next frame from slot 0
					hist_cnt <= {1'b0, wr_ptr} + 1'b1;
					frame_ok <= 1'b1;
				end else begin
					wr_ptr   <= wr_ptr + 1'b1;
					frame_ok <= 1'b0;                   // open frame blocks pairing
				end
			end
			if (cur_fire) begin
				emitting <= 1'b1;
				emit_idx <= '0;
			end else if (pair_fire) begin
				if (last_pair) begin
					emitting  <= 1'b0;
					cur_idx_q <= cur_idx_q + 1'b1;  // wraps at depth
				end else begin
					emit_idx <= emit_idx + 1'b1;
				end
			end
		end
	end

	// held pair must not move under back-pressure
	a_pair_stable: assert property (@(posedge clk) disable iff (!reset_N)
		pair_valid && !pair_ready |=> pair_valid && $stable(pair));

endmodule

//--- oflow_div_seq.sv
// ------------------------------
// restoring sequential divider
// one quotient bit per cycle, first bit on
// the start edge, done pulse with last bit
// ------------------------------
`timescale 1ns/1ps
`include "oflow_params.svh"

module oflow_div_seq #(
	parameter int DIVIDEND_W = `OFLOW_AREA_W + `OFLOW_FRAC_W,
	parameter int DIVISOR_W  = `OFLOW_UNION_W,
	parameter int QUOT_W     = `OFLOW_QUOT_W
) (
	input  logic                  clk,
	input  logic                  reset_N,
	input  logic                  start,
	input  logic [DIVIDEND_W-1:0] dividend,
	input  logic [DIVISOR_W-1:0]  divisor,
	output logic                  done,
	output logic [QUOT_W-1:0]     quotient
);

	localparam int CNT_W = $clog2(QUOT_W + 1);

	logic [DIVISOR_W-1:0] rem_q;     // partial remainder
	logic [DIVISOR_W-1:0] rem_in;
	logic [DIVISOR_W-1:0] rem_nx;
	logic [QUOT_W-1:0]    quot_q;    // low dividend bits out, quotient bits in
	logic [QUOT_W-1:0]    quot_in;
	logic [QUOT_W-1:0]    quot_nx;
	logic [DIVISOR_W-1:0] dvs_q;
	logic [DIVISOR_W-1:0] dvs_in;
	logic [DIVISOR_W:0]   trial;
	logic [CNT_W-1:0]     cnt;       // bits retired
	logic                 busy;

	// ------------------------------
	// one restoring step
	// ------------------------------
	always_comb begin
		// upper dividend bits preload the remainder, caller keeps them below divisor
		rem_in  = start ? DIVISOR_W'(dividend[DIVIDEND_W-1:QUOT_W]) : rem_q;
		quot_in = start ? dividend[QUOT_W-1:0] : quot_q;
		dvs_in  = start ? divisor : dvs_q;
		trial   = {rem_in, quot_in[QUOT_W-1]};   // shift next bit in
		if (trial >= {1'b0, dvs_in}) begin
			rem_nx  = DIVISOR_W'(trial - {1'b0, dvs_in});
			quot_nx = {quot_in[QUOT_W-2:0], 1'b1};
		end else begin
			rem_nx  = trial[DIVISOR_W-1:0];      // restore
			quot_nx = {quot_in[QUOT_W-2:0], 1'b0};
		end
	end

	assign quotient = quot_q;

	always_ff @(posedge clk) begin
		if (start || busy) begin
			rem_q  <= rem_nx;
			quot_q <= quot_nx;
			dvs_q  <= dvs_in;
		end
	end

	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			busy <= 1'b0;
			cnt  <= '0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (start) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(1);
			end else if (busy) begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(QUOT_W - 1)) begin
					busy <= 1'b0;
					done <= 1'b1;    // quotient final from here
				end
			end
		end
	end

	a_div_nonzero: assert property (@(posedge clk) disable iff (!reset_N)
		start |-> divisor != '0);

endmodule

//--- oflow_pkg.sv
// ------------------------------
// optical flow tracker, IoU stage
// box, pair and result types
// ------------------------------
`include "oflow_params.svh"

package oflow_pkg;

	// ------------------------------
	// corner box, {x_tl, y_tl, x_br, y_br}
	// ------------------------------
	typedef struct packed {
		logic [`OFLOW_COORD_W-1:0] x_tl;
		logic [`OFLOW_COORD_W-1:0] y_tl;
		logic [`OFLOW_COORD_W-1:0] x_br;
		logic [`OFLOW_COORD_W-1:0] y_br;
	} bbox_t;

	// one association candidate
	typedef struct packed {
		bbox_t                   cur_box;   // frame k
		bbox_t                   hist_box;  // history frame
		logic [`OFLOW_IDX_W-1:0] cur_idx;
		logic [`OFLOW_IDX_W-1:0] hist_idx;
	} bbox_pair_t;

	// cost for one pair, 1 - iou in Q0.22
	typedef struct packed {
		logic [`OFLOW_IDX_W-1:0]  cur_idx;
		logic [`OFLOW_IDX_W-1:0]  hist_idx;
		logic [`OFLOW_FRAC_W-1:0] cost;
	} iou_result_t;

endpackage

//--- oflow_params.svh
// ------------------------------
// optical flow tracker, IoU stage
// width and depth constants shared by
// the pair generator, FIFO and cost block
// ------------------------------
`ifndef OFLOW_PARAMS_SVH
`define OFLOW_PARAMS_SVH

// box geometry
`define OFLOW_COORD_W     10                        // one corner coordinate
`define OFLOW_AREA_W      (2*`OFLOW_COORD_W)        // w*h product
`define OFLOW_UNION_W     (`OFLOW_AREA_W+1)         // sum of two areas

// fixed point cost
`define OFLOW_FRAC_W      22                        // Q0.22 fraction bits
`define OFLOW_QUOT_W      (`OFLOW_FRAC_W+1)         // extra bit for iou == 1.0

// history table
`define OFLOW_HIST_DEPTH  4
`define OFLOW_IDX_W       2                         // box index, wraps at depth

// pair buffer between producer and consumer
`define OFLOW_FIFO_DEPTH  4

`endif
